/* rtl/radio_ctrl_pkg.sv */
// radio control package
// shared widths, word types, stream IDs and setting register map
`default_nettype none

package radio_ctrl_pkg;

    //////////////////////////////////////////////////
    // word and field types
    //////////////////////////////////////////////////

    // command: data[63:32], zero[31:17], write[16], addr[15:8], sid[7:0]
    typedef logic [63:0] cmd_word_t;

    // response: value[63:32], zero[31:11], rb_sel[10:8], sid[7:0]
    typedef logic [63:0] resp_word_t;

    typedef logic [7:0]  sid_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [2:0]  rb_sel_t;
    typedef logic [1:0]  lock_t;    // front-end lock pair

    //////////////////////////////////////////////////
    // channel routing
    //////////////////////////////////////////////////

    localparam int NUM_CHANNELS = 2;

    // only the upper nibble selects the endpoint
    localparam sid_t SID_MASK = 8'hF0;

    // channel k answers to CTRL_SID_BASE * (k+1)
    localparam sid_t CTRL_SID_BASE = 8'h10;

    //////////////////////////////////////////////////
    // setting register map
    //////////////////////////////////////////////////

    localparam reg_addr_t SR_MISC     = 8'd16;
    localparam reg_addr_t SR_READBACK = 8'd32;  // low 3 bits of data only
    localparam reg_addr_t SR_SCRATCH  = 8'd40;

    // compat number, major in the upper half of the readback
    localparam logic [15:0] COMPAT_MAJOR = 16'h000E;
    localparam logic [15:0] COMPAT_MINOR = 16'h0000;

    //////////////////////////////////////////////////
    // readback selector values
    //////////////////////////////////////////////////

    localparam rb_sel_t RB_COMPAT  = 3'd0;
    localparam rb_sel_t RB_MISC    = 3'd1;
    localparam rb_sel_t RB_SCRATCH = 3'd2;
    localparam rb_sel_t RB_LOCK    = 3'd3;
    // 4..7 read back as zero

endpackage

`default_nettype wire

/* rtl/ctrl_router.sv */
// control command router
// holds one command and presents it to the endpoint its SID selects
`timescale 1ns/100ps
`default_nettype none

module ctrl_router (
    input  wire                                         radio_clk,
    input  wire                                         bus_rst,
    input  wire                                         i_cmd_valid,
    input  radio_ctrl_pkg::cmd_word_t                   i_cmd_data,
    output logic                                        o_cmd_ready,
    output logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]     o_cmd_valid,
    output radio_ctrl_pkg::cmd_word_t                   o_cmd_data,
    input  wire  [radio_ctrl_pkg::NUM_CHANNELS-1:0]     i_cmd_ready
);

    logic                                    slot_full;
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0] slot_sel;  // one-hot channel, zero when unmatched
    radio_ctrl_pkg::cmd_word_t               slot_data;

    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0] dst_sel;
    radio_ctrl_pkg::sid_t                    cmd_sid;
    logic                                    slot_drain;
    logic                                    cmd_accept;

    //////////////////////////////////////////////////
    // SID decode on the incoming word
    //////////////////////////////////////////////////

    assign cmd_sid = i_cmd_data[7:0];

    always_comb begin
        dst_sel = '0;
        for (int k = 0; k < radio_ctrl_pkg::NUM_CHANNELS; k++) begin
            if ((cmd_sid & radio_ctrl_pkg::SID_MASK) ==
                radio_ctrl_pkg::sid_t'(radio_ctrl_pkg::CTRL_SID_BASE * (k + 1))) begin
                dst_sel[k] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // command slot
    //////////////////////////////////////////////////

    // unmatched words leave the slot on their own next cycle
    assign slot_drain  = slot_full && ((slot_sel == '0) || ((slot_sel & i_cmd_ready) != '0));
    assign o_cmd_ready = !slot_full || slot_drain;
    assign cmd_accept  = i_cmd_valid && o_cmd_ready;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            slot_full <= 1'b0;
            slot_sel  <= '0;
        end else if (cmd_accept) begin
            slot_full <= 1'b1;
            slot_sel  <= dst_sel;
        end else if (slot_drain) begin
            slot_full <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (cmd_accept) begin
            slot_data <= i_cmd_data;
        end
    end

    // at most one valid, and only for a matched word
    assign o_cmd_valid = slot_full ? slot_sel : '0;
    assign o_cmd_data  = slot_data;

endmodule

`default_nettype wire

/* rtl/radio_ctrl_endpoint.sv */
// radio control endpoint for one channel
// setting registers, lock synchronizer and one registered readback response
`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_endpoint #(
    parameter int CHANNEL = 0
) (
    input  wire                         radio_clk,
    input  wire                         bus_rst,
    input  wire                         i_cmd_valid,
    input  radio_ctrl_pkg::cmd_word_t   i_cmd_data,
    output logic                        o_cmd_ready,
    input  radio_ctrl_pkg::lock_t       i_lock,
    output logic                        o_resp_valid,
    output radio_ctrl_pkg::resp_word_t  o_resp_data,
    input  wire                         i_resp_ready
);

    // own SID, upper nibble from the channel index
    localparam radio_ctrl_pkg::sid_t MY_SID =
        radio_ctrl_pkg::sid_t'(radio_ctrl_pkg::CTRL_SID_BASE * (CHANNEL + 1));

    // command fields
    radio_ctrl_pkg::reg_addr_t  cmd_addr;
    radio_ctrl_pkg::reg_data_t  cmd_value;
    logic                       cmd_write;
    logic                       cmd_accept;

    // setting registers and their next values
    radio_ctrl_pkg::reg_data_t  misc_reg;
    radio_ctrl_pkg::reg_data_t  scratch_reg;
    radio_ctrl_pkg::rb_sel_t    rb_sel;
    radio_ctrl_pkg::reg_data_t  misc_nxt;
    radio_ctrl_pkg::reg_data_t  scratch_nxt;
    radio_ctrl_pkg::rb_sel_t    rb_sel_nxt;

    radio_ctrl_pkg::lock_t      lock_meta;
    radio_ctrl_pkg::lock_t      lock_sync;

    radio_ctrl_pkg::reg_data_t  rb_value;
    logic                       resp_full;
    radio_ctrl_pkg::resp_word_t resp_data;

    assign cmd_addr  = i_cmd_data[15:8];
    assign cmd_write = i_cmd_data[16];
    assign cmd_value = i_cmd_data[63:32];

    // one response slot, refilled on the draining edge
    assign o_cmd_ready = !resp_full || i_resp_ready;
    assign cmd_accept  = i_cmd_valid && o_cmd_ready;

    //////////////////////////////////////////////////
    // setting registers
    //////////////////////////////////////////////////

    always_comb begin
        misc_nxt    = misc_reg;
        scratch_nxt = scratch_reg;
        rb_sel_nxt  = rb_sel;
        if (cmd_accept && cmd_write) begin
            case (cmd_addr)
                radio_ctrl_pkg::SR_MISC:     misc_nxt    = cmd_value;
                radio_ctrl_pkg::SR_SCRATCH:  scratch_nxt = cmd_value;
                radio_ctrl_pkg::SR_READBACK: rb_sel_nxt  = cmd_value[2:0];
                default: ;  // unknown address, nothing written
            endcase
        end
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            misc_reg    <= '0;
            scratch_reg <= '0;
            rb_sel      <= '0;
        end else begin
            misc_reg    <= misc_nxt;
            scratch_reg <= scratch_nxt;
            rb_sel      <= rb_sel_nxt;
        end
    end

    // two-flop synchronizer for the async lock pair
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock;
            lock_sync <= lock_meta;
        end
    end

    //////////////////////////////////////////////////
    // readback response
    //////////////////////////////////////////////////

    // selected from post-write values so a same-command selector change counts
    always_comb begin
        case (rb_sel_nxt)
            radio_ctrl_pkg::RB_COMPAT:  rb_value = {radio_ctrl_pkg::COMPAT_MAJOR,
                                                   radio_ctrl_pkg::COMPAT_MINOR};
            radio_ctrl_pkg::RB_MISC:    rb_value = misc_nxt;
            radio_ctrl_pkg::RB_SCRATCH: rb_value = scratch_nxt;
            radio_ctrl_pkg::RB_LOCK:    rb_value = {30'd0, lock_sync};
            default:                    rb_value = '0;
        endcase
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            resp_full <= 1'b0;
        end else if (cmd_accept) begin
            resp_full <= 1'b1;
        end else if (i_resp_ready) begin
            resp_full <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (cmd_accept) begin
            resp_data <= {rb_value, 21'd0, rb_sel_nxt, MY_SID};
        end
    end

    assign o_resp_valid = resp_full;
    assign o_resp_data  = resp_data;

endmodule

`default_nettype wire

/* rtl/resp_merger.sv */
// response merger
// round-robin grant over the endpoint responses into one output register
`timescale 1ns/100ps
`default_nettype none

module resp_merger (
    input  wire                                             radio_clk,
    input  wire                                             bus_rst,
    input  wire  [radio_ctrl_pkg::NUM_CHANNELS-1:0]         i_resp_valid,
    input  radio_ctrl_pkg::resp_word_t [radio_ctrl_pkg::NUM_CHANNELS-1:0] i_resp_data,
    output logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]         o_resp_ready,
    output logic                                            o_resp_valid,
    output radio_ctrl_pkg::resp_word_t                      o_resp_data,
    input  wire                                             i_resp_ready
);

    logic                                    out_full;
    radio_ctrl_pkg::resp_word_t              out_data;
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0] last_gnt;  // one-hot, zero after reset

    logic                                    slot_free;
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0] gnt;
    radio_ctrl_pkg::resp_word_t              gnt_data;

    assign slot_free = !out_full || i_resp_ready;

    //////////////////////////////////////////////////
    // round-robin arbiter
    //////////////////////////////////////////////////

    always_comb begin
        int last_idx;
        int idx;
        logic found;
        last_idx = radio_ctrl_pkg::NUM_CHANNELS - 1;  // channel 0 first after reset
        found    = 1'b0;
        gnt      = '0;
        gnt_data = '0;
        for (int k = 0; k < radio_ctrl_pkg::NUM_CHANNELS; k++) begin
            if (last_gnt[k]) begin
                last_idx = k;
            end
        end
        // search starts just past the last winner
        for (int off = 1; off <= radio_ctrl_pkg::NUM_CHANNELS; off++) begin
            idx = (last_idx + off) % radio_ctrl_pkg::NUM_CHANNELS;
            if (slot_free && !found && i_resp_valid[idx]) begin
                gnt[idx] = 1'b1;
                gnt_data = i_resp_data[idx];
                found    = 1'b1;
            end
        end
    end

    assign o_resp_ready = gnt;

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            out_full <= 1'b0;
            last_gnt <= '0;
        end else begin
            if (slot_free) begin
                out_full <= |gnt;
            end
            if (|gnt) begin
                last_gnt <= gnt;
            end
        end
    end

    always_ff @(posedge radio_clk) begin
        if (|gnt) begin
            out_data <= gnt_data;
        end
    end

    assign o_resp_valid = out_full;
    assign o_resp_data  = out_data;

endmodule

`default_nettype wire

/* rtl/radio_ctrl_core.sv */
// radio control core
// command router, one control endpoint per channel and the response merger
`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_core (
    input  wire                                                 radio_clk,
    input  wire                                                 bus_rst,
    input  wire                                                 i_cmd_valid,
    input  radio_ctrl_pkg::cmd_word_t                           i_cmd_data,
    output logic                                                o_cmd_ready,
    input  radio_ctrl_pkg::lock_t [radio_ctrl_pkg::NUM_CHANNELS-1:0] i_lock,
    output logic                                                o_resp_valid,
    output radio_ctrl_pkg::resp_word_t                          o_resp_data,
    input  wire                                                 i_resp_ready
);

    // router to endpoints
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]  cmd_valid;
    radio_ctrl_pkg::cmd_word_t                cmd_data;   // shared by all endpoints
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]  cmd_ready;

    // endpoints to merger
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]  resp_valid;
    radio_ctrl_pkg::resp_word_t [radio_ctrl_pkg::NUM_CHANNELS-1:0] resp_data;
    logic [radio_ctrl_pkg::NUM_CHANNELS-1:0]  resp_ready;

    //////////////////////////////////////////////////
    // command routing
    //////////////////////////////////////////////////

    ctrl_router u_router (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_data  (i_cmd_data),
        .o_cmd_ready (o_cmd_ready),
        .o_cmd_valid (cmd_valid),
        .o_cmd_data  (cmd_data),
        .i_cmd_ready (cmd_ready)
    );

    //////////////////////////////////////////////////
    // control endpoints
    //////////////////////////////////////////////////

    for (genvar g = 0; g < radio_ctrl_pkg::NUM_CHANNELS; g++) begin : g_chan
        radio_ctrl_endpoint #(
            .CHANNEL (g)
        ) u_endpoint (
            .radio_clk    (radio_clk),
            .bus_rst      (bus_rst),
            .i_cmd_valid  (cmd_valid[g]),
            .i_cmd_data   (cmd_data),
            .o_cmd_ready  (cmd_ready[g]),
            .i_lock       (i_lock[g]),
            .o_resp_valid (resp_valid[g]),
            .o_resp_data  (resp_data[g]),
            .i_resp_ready (resp_ready[g])
        );
    end

    //////////////////////////////////////////////////
    // response merge
    //////////////////////////////////////////////////

    resp_merger u_merger (
        .radio_clk    (radio_clk),
        .bus_rst      (bus_rst),
        .i_resp_valid (resp_valid),
        .i_resp_data  (resp_data),
        .o_resp_ready (resp_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready)
    );

endmodule

`default_nettype wire

/* verification/radio_ctrl_assert.sv */
// radio control core assertions
// response handshake rules and one-hot router valids, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_assert (
    input  wire                                         radio_clk,
    input  wire                                         bus_rst,
    input  wire                                         i_resp_valid,
    input  radio_ctrl_pkg::resp_word_t                  i_resp_data,
    input  wire                                         i_resp_ready,
    input  wire  [radio_ctrl_pkg::NUM_CHANNELS-1:0]     i_router_valid
);

    // output register cleared by the reset edge
    resp_low_in_reset: assert property (
        @(posedge radio_clk) bus_rst |=> !i_resp_valid
    ) else $error("o_resp_valid high during reset");

    // a stalled word holds until it is taken
    resp_stable_in_stall: assert property (
        @(posedge radio_clk) disable iff (bus_rst)
        (i_resp_valid && !i_resp_ready) |=> (i_resp_valid && $stable(i_resp_data))
    ) else $error("o_resp_valid or o_resp_data changed while stalled");

    router_onehot_valid: assert property (
        @(posedge radio_clk) disable iff (bus_rst)
        $onehot0(i_router_valid)
    ) else $error("more than one router output valid");

endmodule

// attach to every radio_ctrl_core instance
bind radio_ctrl_core radio_ctrl_assert u_assert (
    .radio_clk      (radio_clk),
    .bus_rst        (bus_rst),
    .i_resp_valid   (o_resp_valid),
    .i_resp_data    (o_resp_data),
    .i_resp_ready   (i_resp_ready),
    .i_router_valid (cmd_valid)
);

`default_nettype wire

/* verification/tb_radio_ctrl_core.sv */
// radio control core testbench
// table of commands and expected readbacks, run with open and random response ready
`timescale 1ns/100ps
`default_nettype none

module tb_radio_ctrl_core;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 16;
    localparam int WAIT_CYCLES  = 20;
    // two passes, each row at most 40 cycles, plus resets and final idle check
    localparam int WATCHDOG_CYCLES = 2 * NUM_ROWS * 40 + 2 * RESET_CYCLES + 2 * WAIT_CYCLES;

    logic                                                   radio_clk;
    logic                                                   bus_rst;
    logic                                                   i_cmd_valid;
    radio_ctrl_pkg::cmd_word_t                              i_cmd_data;
    logic                                                   o_cmd_ready;
    radio_ctrl_pkg::lock_t [radio_ctrl_pkg::NUM_CHANNELS-1:0] i_lock;
    logic                                                   o_resp_valid;
    radio_ctrl_pkg::resp_word_t                             o_resp_data;
    logic                                                   i_resp_ready;

    // stimulus and expected values, one entry per row
    radio_ctrl_pkg::sid_t      tbl_sid      [NUM_ROWS];
    radio_ctrl_pkg::reg_addr_t tbl_addr     [NUM_ROWS];
    logic                      tbl_wr       [NUM_ROWS];
    radio_ctrl_pkg::reg_data_t tbl_data     [NUM_ROWS];
    logic                      tbl_exp_resp [NUM_ROWS];
    radio_ctrl_pkg::sid_t      tbl_exp_sid  [NUM_ROWS];
    radio_ctrl_pkg::rb_sel_t   tbl_exp_sel  [NUM_ROWS];
    radio_ctrl_pkg::reg_data_t tbl_exp_val  [NUM_ROWS];

    int     row_count;
    int     resp_seen;
    int     resp_expected;
    integer seed;
    integer ready_draw;
    logic   rand_ready;

    radio_ctrl_core i_dut (
        .radio_clk    (radio_clk),
        .bus_rst      (bus_rst),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_data   (i_cmd_data),
        .o_cmd_ready  (o_cmd_ready),
        .i_lock       (i_lock),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready)
    );

    initial radio_clk = 1'b0;
    always #(CLK_PERIOD / 2) radio_clk = ~radio_clk;

    // response ready, open or random per cycle
    always @(posedge radio_clk) begin
        #1;
        if (rand_ready) begin
            ready_draw = $random(seed);
            i_resp_ready = ready_draw[0];
        end else begin
            i_resp_ready = 1'b1;
        end
    end

    // every response handshake, so lost or repeated words show in the count
    always @(negedge radio_clk) begin
        if (!bus_rst && o_resp_valid && i_resp_ready) begin
            resp_seen++;
        end
    end

    //////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish in the allowed time");
        abort_run();
    end

    //////////////////////////////////////////////////
    // table and sequencing helpers
    //////////////////////////////////////////////////

    task automatic add_row(input logic [7:0] sid, input logic [7:0] addr, input logic wr,
                           input logic [31:0] data, input logic exp_resp,
                           input logic [7:0] exp_sid, input logic [2:0] exp_sel,
                           input logic [31:0] exp_val);
        tbl_sid[row_count]      = sid;
        tbl_addr[row_count]     = addr;
        tbl_wr[row_count]       = wr;
        tbl_data[row_count]     = data;
        tbl_exp_resp[row_count] = exp_resp;
        tbl_exp_sid[row_count]  = exp_sid;
        tbl_exp_sel[row_count]  = exp_sel;
        tbl_exp_val[row_count]  = exp_val;
        row_count++;
    endtask

    task automatic load_table();
        row_count = 0;
        // compat on both channels
        add_row(8'h10, 8'd0,  1'b0, 32'h0,         1'b1, 8'h10, 3'd0, 32'h000E_0000);
        add_row(8'h20, 8'd0,  1'b0, 32'h0,         1'b1, 8'h20, 3'd0, 32'h000E_0000);
        // misc on ch0, ch1 misc untouched
        add_row(8'h10, 8'd16, 1'b1, 32'hA5A5_0001, 1'b1, 8'h10, 3'd0, 32'h000E_0000);
        add_row(8'h10, 8'd32, 1'b1, 32'h1,         1'b1, 8'h10, 3'd1, 32'hA5A5_0001);
        add_row(8'h20, 8'd32, 1'b1, 32'h1,         1'b1, 8'h20, 3'd1, 32'h0);
        // scratch on ch1, ch0 scratch untouched
        add_row(8'h20, 8'd40, 1'b1, 32'h1234_5678, 1'b1, 8'h20, 3'd1, 32'h0);
        add_row(8'h20, 8'd32, 1'b1, 32'h2,         1'b1, 8'h20, 3'd2, 32'h1234_5678);
        add_row(8'h10, 8'd32, 1'b1, 32'h2,         1'b1, 8'h10, 3'd2, 32'h0);
        // lock pairs, then an unknown address
        add_row(8'h10, 8'd32, 1'b1, 32'h3,         1'b1, 8'h10, 3'd3, 32'h2);
        add_row(8'h20, 8'd32, 1'b1, 32'h3,         1'b1, 8'h20, 3'd3, 32'h1);
        add_row(8'h20, 8'd85, 1'b1, 32'hFFFF_FFFF, 1'b1, 8'h20, 3'd3, 32'h1);
        // unmatched SID dropped, next command still answered
        add_row(8'h70, 8'd0,  1'b0, 32'h0,         1'b0, 8'h00, 3'd0, 32'h0);
        add_row(8'h20, 8'd32, 1'b1, 32'h2,         1'b1, 8'h20, 3'd2, 32'h1234_5678);
        // unused selector, then misc again, low SID nibble ignored
        add_row(8'h10, 8'd32, 1'b1, 32'hFFFF_FFF5, 1'b1, 8'h10, 3'd5, 32'h0);
        add_row(8'h10, 8'd32, 1'b1, 32'h1,         1'b1, 8'h10, 3'd1, 32'hA5A5_0001);
        add_row(8'h1F, 8'd0,  1'b0, 32'h0,         1'b1, 8'h10, 3'd1, 32'hA5A5_0001);
    endtask

    task automatic apply_reset();
        bus_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge radio_clk);
        #1;
        bus_rst = 1'b0;
        // idle and open for a command right out of reset
        check_value("o_cmd_ready", o_cmd_ready, 1);
        check_value("o_resp_valid", o_resp_valid, 0);
    endtask

    // switch ready mode away from the drive point of the ready process
    task automatic set_ready_mode(input logic en);
        @(negedge radio_clk);
        rand_ready = en;
        @(posedge radio_clk);
        #1;
    endtask

    task automatic send_cmd(input int idx);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        i_cmd_data  = {tbl_data[idx], 15'd0, tbl_wr[idx], tbl_addr[idx], tbl_sid[idx]};
        i_cmd_valid = 1'b1;
        while (!accepted) begin
            @(negedge radio_clk);
            if (o_cmd_ready) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited >= WAIT_CYCLES) begin
                    $display("command of row %0d was not accepted within %0d cycles",
                             idx, WAIT_CYCLES);
                    abort_run();
                end
            end
        end
        @(posedge radio_clk);   // transfer edge
        #1;
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_response(input int idx);
        int                         cycles;
        logic                       got;
        radio_ctrl_pkg::resp_word_t resp;
        got  = 1'b0;
        resp = '0;
        cycles = 0;
        while (!got && cycles < WAIT_CYCLES) begin
            @(negedge radio_clk);
            cycles++;
            if (o_resp_valid) begin
                if (!tbl_exp_resp[idx]) begin
                    $display("row %0d gave a response although none was expected", idx);
                    abort_run();
                end
                if (i_resp_ready) begin
                    got  = 1'b1;
                    resp = o_resp_data;
                end
            end
        end
        @(posedge radio_clk);
        #1;
        if (tbl_exp_resp[idx]) begin
            if (!got) begin
                $display("row %0d got no response within %0d cycles", idx, WAIT_CYCLES);
                abort_run();
            end
            if (!rand_ready) begin
                check_value("response latency", cycles, 3);
            end
            check_value("o_resp_data.sid", resp[7:0], tbl_exp_sid[idx]);
            check_value("o_resp_data.rb_sel", resp[10:8], tbl_exp_sel[idx]);
            check_value("o_resp_data.zero", resp[31:11], 0);
            check_value("o_resp_data.value", resp[63:32], tbl_exp_val[idx]);
        end
    endtask

    task automatic run_table();
        for (int r = 0; r < row_count; r++) begin
            send_cmd(r);
            wait_response(r);
            if (tbl_exp_resp[r]) begin
                resp_expected++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed          = 16;
        rand_ready    = 1'b0;
        bus_rst       = 1'b1;
        i_cmd_valid   = 1'b0;
        i_cmd_data    = '0;
        i_resp_ready  = 1'b1;
        i_lock[0]     = 2'h2;
        i_lock[1]     = 2'h1;
        resp_seen     = 0;
        resp_expected = 0;
        load_table();

        apply_reset();
        run_table();            // ready held high

        apply_reset();          // registers back to reset values for the replay
        set_ready_mode(1'b1);
        run_table();            // ready random
        set_ready_mode(1'b0);

        // nothing left over after the last row
        repeat (WAIT_CYCLES) begin
            @(negedge radio_clk);
            if (o_resp_valid) begin
                $display("an extra response appeared after the last row");
                abort_run();
            end
        end

        if (resp_seen == resp_expected) begin
            $display("No errors");
            $finish;
        end else begin
            $display("response count %0d does not match %0d", resp_seen, resp_expected);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* files.f */
rtl/radio_ctrl_pkg.sv
rtl/ctrl_router.sv
rtl/radio_ctrl_endpoint.sv
rtl/resp_merger.sv
rtl/radio_ctrl_core.sv
verification/radio_ctrl_assert.sv
verification/tb_radio_ctrl_core.sv

/* Bender.yml */
package:
  name: radio_ctrl_core

sources:
  - files:
      - rtl/radio_ctrl_pkg.sv
      - rtl/ctrl_router.sv
      - rtl/radio_ctrl_endpoint.sv
      - rtl/resp_merger.sv
      - rtl/radio_ctrl_core.sv
  - target: test
    files:
      - verification/radio_ctrl_assert.sv
      - verification/tb_radio_ctrl_core.sv
